// File: b_cache_din_map.f
+incdir+source
+incdir+tb
source/b_cache_pkg.sv
source/fix_div.sv
source/cov_inverse.sv
source/cache_din_mux.sv
source/b_cache_din_map.sv
tb/tb_b_cache_din_map.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the b_cache_din_map testbench

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --top-module tb_b_cache_din_map -f b_cache_din_map.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Everything OK" "$log"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// File: source/b_cache_din_map.sv
`timescale 1ns/10ps

module b_cache_din_map (
  input  logic                    clk,
  input  logic                    sys_rst,
  input  b_cache_pkg::write_sel_t cache_in_sel,
  input  b_cache_pkg::seq_cnt_t   seq_cnt,
  input  b_cache_pkg::lane_vec_t  c_din,
  input  logic                    s_valid,
  output logic                    s_ready,
  output logic                    done_inv,
  input  b_cache_pkg::word_t      hxi_11,
  input  b_cache_pkg::word_t      hxi_12,
  input  b_cache_pkg::word_t      hxi_21,
  input  b_cache_pkg::word_t      hxi_22,
  input  b_cache_pkg::word_t      hz_11,
  input  b_cache_pkg::word_t      hz_12,
  input  b_cache_pkg::word_t      hz_21,
  input  b_cache_pkg::word_t      hz_22,
  input  b_cache_pkg::word_t      vt_1,
  input  b_cache_pkg::word_t      vt_2,
  output b_cache_pkg::lane_vec_t  cache_din
);

  // inverse of S, held until the next completion
  b_cache_pkg::word_t inv_11;
  b_cache_pkg::word_t inv_12;
  b_cache_pkg::word_t inv_22;

  cov_inverse i_cov_inverse (
    .clk      (clk),
    .sys_rst  (sys_rst),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .c_din    (c_din),
    .done_inv (done_inv),
    .inv_11   (inv_11),
    .inv_12   (inv_12),
    .inv_22   (inv_22)
  );

  cache_din_mux i_cache_din_mux (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .cache_in_sel (cache_in_sel),
    .seq_cnt      (seq_cnt),
    .c_din        (c_din),
    .inv_11       (inv_11),
    .inv_12       (inv_12),
    .inv_22       (inv_22),
    .hxi_11       (hxi_11),
    .hxi_12       (hxi_12),
    .hxi_21       (hxi_21),
    .hxi_22       (hxi_22),
    .hz_11        (hz_11),
    .hz_12        (hz_12),
    .hz_21        (hz_21),
    .hz_22        (hz_22),
    .vt_1         (vt_1),
    .vt_2         (vt_2),
    .cache_din    (cache_din)
  );

endmodule

// File: source/b_cache_pkg.sv
`include "b_cache_settings.svh"

package b_cache_pkg;

  // one cache word, Q1.12.19
  typedef logic signed [`B_CACHE_DW-1:0] word_t;

  // lane 0 first
  typedef word_t lane_vec_t [`B_CACHE_LANES];

  typedef logic [`B_CACHE_SEQ_W-1:0] seq_cnt_t;

  // write modes, codes shared with the cache controller
  typedef enum logic [3:0] {
    WR_IDLE   = 4'b0000,
    WR_INV    = 4'b1010,
    WR_CHI    = 4'b1011,
    WR_NL_UPD = 4'b1111
  } write_sel_t;

endpackage

// File: source/b_cache_settings.svh
`ifndef B_CACHE_SETTINGS_SVH
`define B_CACHE_SETTINGS_SVH

// cache word and lane geometry
`define B_CACHE_DW     32
`define B_CACHE_LANES  4

// Q1.12.19 fixed point
`define B_CACHE_FRAC   19
`define B_CACHE_ONE    32'h80000

// measurement noise, already quantized
`define B_CACHE_Q11    131072
`define B_CACHE_Q22    3992

// write sequence step counter
`define B_CACHE_SEQ_W  5

`endif

// File: source/cache_din_mux.sv
`timescale 1ns/10ps
`include "b_cache_settings.svh"

module cache_din_mux (
  input  logic                    clk,
  input  logic                    sys_rst,
  input  b_cache_pkg::write_sel_t cache_in_sel,
  input  b_cache_pkg::seq_cnt_t   seq_cnt,
  input  b_cache_pkg::lane_vec_t  c_din,
  input  b_cache_pkg::word_t      inv_11,
  input  b_cache_pkg::word_t      inv_12,
  input  b_cache_pkg::word_t      inv_22,
  input  b_cache_pkg::word_t      hxi_11,
  input  b_cache_pkg::word_t      hxi_12,
  input  b_cache_pkg::word_t      hxi_21,
  input  b_cache_pkg::word_t      hxi_22,
  input  b_cache_pkg::word_t      hz_11,
  input  b_cache_pkg::word_t      hz_12,
  input  b_cache_pkg::word_t      hz_21,
  input  b_cache_pkg::word_t      hz_22,
  input  b_cache_pkg::word_t      vt_1,
  input  b_cache_pkg::word_t      vt_2,
  output b_cache_pkg::lane_vec_t  cache_din
);

  b_cache_pkg::lane_vec_t din_nxt;
  b_cache_pkg::word_t     minus_one;

  assign minus_one = -b_cache_pkg::word_t'(`B_CACHE_ONE);

  // lanes 2 and 3 never written in these modes
  always_comb begin
    din_nxt = '{default: '0};
    case (cache_in_sel)
      b_cache_pkg::WR_INV: begin
        case (seq_cnt)
          'd1: din_nxt[0] = inv_11;
          'd2: begin
            din_nxt[0] = inv_12;
            din_nxt[1] = inv_12;   // symmetric
          end
          'd3: din_nxt[1] = inv_22;
          default: ;
        endcase
      end
      b_cache_pkg::WR_CHI: begin
        if (seq_cnt == 'd10 || seq_cnt == 'd12) din_nxt[0] = c_din[0];
      end
      b_cache_pkg::WR_NL_UPD: begin
        case (seq_cnt)
          'd1: din_nxt[0] = hxi_11;
          'd2: begin
            din_nxt[0] = hxi_12;
            din_nxt[1] = hxi_21;
          end
          'd3: din_nxt[1] = hxi_22;
          'd4: begin
            din_nxt[0] = hz_11;
            din_nxt[1] = minus_one;
          end
          'd5: begin
            din_nxt[0] = hz_12;
            din_nxt[1] = hz_21;
          end
          'd6: begin
            din_nxt[0] = vt_1;
            din_nxt[1] = hz_22;
          end
          'd7: din_nxt[0] = vt_2;
          default: ;
        endcase
      end
      default: ;   // idle and unused codes
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) cache_din <= '{default: '0};
    else cache_din <= din_nxt;
  end

endmodule

// File: source/cov_inverse.sv
`timescale 1ns/10ps
`include "b_cache_settings.svh"

module cov_inverse (
  input  logic                   clk,
  input  logic                   sys_rst,
  input  logic                   s_valid,
  output logic                   s_ready,
  input  b_cache_pkg::lane_vec_t c_din,
  output logic                   done_inv,
  output b_cache_pkg::word_t     inv_11,
  output b_cache_pkg::word_t     inv_12,
  output b_cache_pkg::word_t     inv_22
);

  typedef enum logic [2:0] {IDLE, PROD, DET, D11, D12, D22, DONE} state_t;

  state_t state;
  state_t state_nxt;
  logic   prod_cnt;   // which product is in the multiplier

  b_cache_pkg::word_t s21;
  b_cache_pkg::word_t s11q;
  b_cache_pkg::word_t s22q;
  b_cache_pkg::word_t mul_a;
  b_cache_pkg::word_t mul_b;
  logic signed [2*`B_CACHE_DW-1:0] mul_p;
  b_cache_pkg::word_t mul_c;
  b_cache_pkg::word_t p21;
  b_cache_pkg::word_t p1122;
  b_cache_pkg::word_t det;   // also the divisor for all three divisions
  b_cache_pkg::word_t dividend;

  logic               div_start;
  logic               div_done;
  b_cache_pkg::word_t quotient;

  assign mul_p = (2*`B_CACHE_DW)'(mul_a) * (2*`B_CACHE_DW)'(mul_b);
  assign mul_c = {mul_p[2*`B_CACHE_DW-1], mul_p[`B_CACHE_FRAC +: `B_CACHE_DW-1]};

  assign s_ready  = (state == IDLE);
  assign done_inv = (state == DONE);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: if (s_valid) state_nxt = PROD;
      PROD: if (prod_cnt) state_nxt = DET;
      DET:  state_nxt = D11;
      D11:  if (div_done) state_nxt = D12;
      D12:  if (div_done) state_nxt = D22;
      D22:  if (div_done) state_nxt = DONE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state     <= IDLE;
      prod_cnt  <= 1'b0;
      div_start <= 1'b0;
    end else begin
      state     <= state_nxt;
      prod_cnt  <= (state == PROD) && !prod_cnt;
      div_start <= (state == DET) || (div_done && (state == D11 || state == D12));
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      IDLE: if (s_valid) begin
        s21   <= c_din[1];
        s11q  <= c_din[0] + `B_CACHE_Q11;
        s22q  <= c_din[2] + `B_CACHE_Q22;
        mul_a <= c_din[1];   // S21*S21 first
        mul_b <= c_din[1];
      end
      PROD: begin
        if (!prod_cnt) begin
          p21   <= mul_c;
          mul_a <= s11q;
          mul_b <= s22q;
        end else begin
          p1122 <= mul_c;
        end
      end
      DET: begin
        det      <= p1122 - p21;
        dividend <= s22q;
      end
      D11: if (div_done) dividend <= -s21;
      D12: if (div_done) dividend <= s11q;
      default: ;
    endcase
  end

  // results by the state the division belongs to
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      inv_11 <= '0;
      inv_12 <= '0;
      inv_22 <= '0;
    end else if (div_done) begin
      case (state)
        D11: inv_11 <= quotient;
        D12: inv_12 <= quotient;
        D22: inv_22 <= quotient;
        default: ;
      endcase
    end
  end

  fix_div i_fix_div (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .div_start (div_start),
    .dividend  (dividend),
    .divisor   (det),
    .div_done  (div_done),
    .quotient  (quotient)
  );

endmodule

// File: source/fix_div.sv
`timescale 1ns/10ps
`include "b_cache_settings.svh"

module fix_div #(
  parameter int width = `B_CACHE_DW,
  parameter int frac  = `B_CACHE_FRAC
) (
  input  logic               clk,
  input  logic               sys_rst,
  input  logic               div_start,
  input  b_cache_pkg::word_t dividend,
  input  b_cache_pkg::word_t divisor,
  output logic               div_done,
  output b_cache_pkg::word_t quotient
);

  localparam int num_w = width + frac;   // dividend shifted up by frac
  localparam int cnt_w = $clog2(num_w);

  logic             busy;
  logic [cnt_w-1:0] cnt;
  logic             last_step;
  logic [num_w-1:0] num;   // numerator out at the top and quotient in at the bottom
  logic [width-1:0] den;
  logic [width-1:0] rem;
  logic             neg;
  logic             zero_div;

  logic [width-1:0] abs_dividend;
  logic [width-1:0] abs_divisor;
  logic [width:0]   trial;
  logic             fits;
  logic [width:0]   rem_sub;
  logic [num_w-1:0] num_nxt;
  logic [width-2:0] mag;

  assign abs_dividend = dividend[width-1] ? -dividend : dividend;
  assign abs_divisor  = divisor[width-1] ? -divisor : divisor;

  // one restoring step
  assign trial     = {rem, num[num_w-1]};
  assign fits      = trial >= {1'b0, den};
  assign rem_sub   = fits ? trial - {1'b0, den} : trial;
  assign num_nxt   = {num[num_w-2:0], fits};
  assign last_step = busy && (cnt == cnt_w'(num_w - 1));

  // saturate on a zero divisor or keep the low 31 bits
  assign mag = zero_div ? '1 : num_nxt[width-2:0];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      busy     <= 1'b0;
      cnt      <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= last_step;
      if (!busy) begin
        cnt <= '0;
        if (div_start) busy <= 1'b1;   // start ignored while busy
      end else begin
        cnt <= cnt + cnt_w'(1);
        if (last_step) busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && div_start) begin
      num      <= {abs_dividend, {frac{1'b0}}};
      den      <= abs_divisor;
      rem      <= '0;
      neg      <= dividend[width-1] ^ divisor[width-1];
      zero_div <= (divisor == '0);
    end else if (busy) begin
      num <= num_nxt;
      rem <= rem_sub[width-1:0];
    end
    if (last_step) quotient <= neg ? -{1'b0, mag} : {1'b0, mag};
  end

endmodule

// File: tb/b_cache_model.svh
`ifndef B_CACHE_MODEL_SVH
`define B_CACHE_MODEL_SVH

// full 64-bit product, keep sign and bits 49..19
function automatic b_cache_pkg::word_t mul_ref(input b_cache_pkg::word_t a,
                                               input b_cache_pkg::word_t b);
  longint p;
  p = longint'(a) * longint'(b);
  return {p[63], p[49:19]};
endfunction

// floor(|n| * 2^19 / |d|), 31 bits, sign from the operands
function automatic b_cache_pkg::word_t div_ref(input b_cache_pkg::word_t n,
                                               input b_cache_pkg::word_t d);
  longint      an;
  longint      ad;
  longint      q;
  logic [30:0] mag;
  an = (n < 0) ? -longint'(n) : longint'(n);
  ad = (d < 0) ? -longint'(d) : longint'(d);
  if (ad == 0) begin
    mag = '1;   // saturate
  end else begin
    q   = (an << `B_CACHE_FRAC) / ad;
    mag = q[30:0];
  end
  if (n[31] ^ d[31]) return -{1'b0, mag};
  return {1'b0, mag};
endfunction

function automatic void inv_ref(input b_cache_pkg::word_t s11, input b_cache_pkg::word_t s21,
                                input b_cache_pkg::word_t s22, output b_cache_pkg::word_t i11,
                                output b_cache_pkg::word_t i12, output b_cache_pkg::word_t i22);
  b_cache_pkg::word_t s11q;
  b_cache_pkg::word_t s22q;
  b_cache_pkg::word_t det;
  s11q = s11 + `B_CACHE_Q11;
  s22q = s22 + `B_CACHE_Q22;
  det  = mul_ref(s11q, s22q) - mul_ref(s21, s21);
  i11  = div_ref(s22q, det);
  i12  = div_ref(-s21, det);
  i22  = div_ref(s11q, det);
endfunction

function automatic void inv_map(input int step, input b_cache_pkg::word_t i11,
                                input b_cache_pkg::word_t i12, input b_cache_pkg::word_t i22,
                                output b_cache_pkg::lane_vec_t want);
  want = '{default: '0};
  case (step)
    1: want[0] = i11;
    2: begin
      want[0] = i12;
      want[1] = i12;
    end
    3: want[1] = i22;
    default: ;
  endcase
endfunction

function automatic void chi_map(input int step, input b_cache_pkg::word_t c0,
                                output b_cache_pkg::lane_vec_t want);
  want = '{default: '0};
  if (step == 10 || step == 12) want[0] = c0;
endfunction

// h: hxi_11 hxi_12 hxi_21 hxi_22 hz_11 hz_12 hz_21 hz_22 vt_1 vt_2
function automatic void nl_upd_map(input int step, input b_cache_pkg::word_t h [10],
                                   output b_cache_pkg::lane_vec_t want);
  want = '{default: '0};
  case (step)
    1: want[0] = h[0];
    2: begin
      want[0] = h[1];
      want[1] = h[2];
    end
    3: want[1] = h[3];
    4: begin
      want[0] = h[4];
      want[1] = -b_cache_pkg::word_t'(`B_CACHE_ONE);
    end
    5: begin
      want[0] = h[5];
      want[1] = h[6];
    end
    6: begin
      want[0] = h[8];
      want[1] = h[7];
    end
    7: want[0] = h[9];
    default: ;
  endcase
endfunction

task automatic check_word(input b_cache_pkg::word_t got, input b_cache_pkg::word_t want,
                          input string msg);
  if (got !== want) begin
    $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, want);
    fail_stop();
  end
endtask

task automatic check_lanes(input b_cache_pkg::lane_vec_t got,
                           input b_cache_pkg::lane_vec_t want, input string msg);
  for (int i = 0; i < `B_CACHE_LANES; i++) begin
    check_word(got[i], want[i], $sformatf("%s lane %0d", msg, i));
  end
endtask

task automatic check_bit(input logic got, input logic want, input string msg);
  if (got !== want) begin
    $display("Mismatch at %0t ns: %s, got %b, expected %b", $time, msg, got, want);
    fail_stop();
  end
endtask

`endif

// File: tb/tb_b_cache_din_map.sv
`timescale 1ns/10ps
`include "b_cache_settings.svh"

module tb_b_cache_din_map;

  logic                    clk;
  logic                    sys_rst;
  b_cache_pkg::write_sel_t cache_in_sel;
  b_cache_pkg::seq_cnt_t   seq_cnt;
  b_cache_pkg::lane_vec_t  c_din;
  logic                    s_valid;
  logic                    s_ready;
  logic                    done_inv;
  b_cache_pkg::word_t      h_words [10];   // hxi, hz, vt in port order
  b_cache_pkg::lane_vec_t  cache_din;
  logic [31:0]             lfsr;

  b_cache_din_map i_b_cache_din_map (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .cache_in_sel (cache_in_sel),
    .seq_cnt      (seq_cnt),
    .c_din        (c_din),
    .s_valid      (s_valid),
    .s_ready      (s_ready),
    .done_inv     (done_inv),
    .hxi_11       (h_words[0]),
    .hxi_12       (h_words[1]),
    .hxi_21       (h_words[2]),
    .hxi_22       (h_words[3]),
    .hz_11        (h_words[4]),
    .hz_12        (h_words[5]),
    .hz_21        (h_words[6]),
    .hz_22        (h_words[7]),
    .vt_1         (h_words[8]),
    .vt_2         (h_words[9]),
    .cache_din    (cache_din)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_stop();
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic timeout_stop(input string what);
    $display("Timeout: %s", what);
    fail_stop();
  endtask

  `include "b_cache_model.svh"

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic randomize_data();
    for (int i = 0; i < `B_CACHE_LANES; i++) c_din[i] = rand_bits(32);
    for (int i = 0; i < 10; i++) h_words[i] = rand_bits(32);
  endtask

  task automatic test_nl_upd();
    b_cache_pkg::lane_vec_t want;
    for (int s = 0; s < 10; s++) begin
      @(negedge clk);
      randomize_data();
      cache_in_sel = b_cache_pkg::WR_NL_UPD;
      seq_cnt      = b_cache_pkg::seq_cnt_t'(s);
      nl_upd_map(s, h_words, want);
      @(negedge clk);
      check_lanes(cache_din, want, $sformatf("nl_upd step %0d", s));
    end
  endtask

  task automatic test_chi();
    b_cache_pkg::lane_vec_t want;
    for (int s = 0; s < 16; s++) begin
      @(negedge clk);
      randomize_data();
      cache_in_sel = b_cache_pkg::WR_CHI;
      seq_cnt      = b_cache_pkg::seq_cnt_t'(s);
      chi_map(s, c_din[0], want);
      @(negedge clk);
      check_lanes(cache_din, want, $sformatf("chi step %0d", s));
    end
  endtask

  task automatic test_unused();
    b_cache_pkg::lane_vec_t want;
    logic [3:0]             code;
    want = '{default: '0};
    for (int k = 0; k < 12; k++) begin
      @(negedge clk);
      randomize_data();
      code = 4'(rand_bits(4));
      if (code == 4'b1010 || code == 4'b1011 || code == 4'b1111) code = 4'b0000;
      cache_in_sel = b_cache_pkg::write_sel_t'(code);
      seq_cnt      = b_cache_pkg::seq_cnt_t'(rand_bits(`B_CACHE_SEQ_W));
      @(negedge clk);
      check_lanes(cache_din, want, $sformatf("unused code %b", code));
    end
  endtask

  task automatic hold_request(input b_cache_pkg::word_t s11, input b_cache_pkg::word_t s21,
                              input b_cache_pkg::word_t s22);
    @(negedge clk);
    c_din[0] = s11;
    c_din[1] = s21;
    c_din[2] = s22;
    s_valid  = 1'b1;
  endtask

  // keep s_valid up until s_ready and let the next rising edge take it
  task automatic accept_request();
    int n;
    n = 0;
    while (!s_ready) begin
      @(negedge clk);
      n++;
      if (n > 1000) timeout_stop("s_ready stayed low for 1000 cycles");
    end
    @(negedge clk);
    s_valid = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 1000) timeout_stop("done_inv did not rise within 1000 cycles");
    end while (!done_inv);
  endtask

  // reads the held inverse back through WR_INV steps 1..3
  task automatic read_inverse(input b_cache_pkg::word_t s11, input b_cache_pkg::word_t s21,
                              input b_cache_pkg::word_t s22);
    b_cache_pkg::word_t     i11;
    b_cache_pkg::word_t     i12;
    b_cache_pkg::word_t     i22;
    b_cache_pkg::lane_vec_t want;
    inv_ref(s11, s21, s22, i11, i12, i22);
    for (int s = 1; s <= 3; s++) begin
      @(negedge clk);
      cache_in_sel = b_cache_pkg::WR_INV;
      seq_cnt      = b_cache_pkg::seq_cnt_t'(s);
      inv_map(s, i11, i12, i22, want);
      @(negedge clk);
      check_lanes(cache_din, want, $sformatf("inverse of %h %h %h step %0d", s11, s21, s22, s));
    end
    cache_in_sel = b_cache_pkg::WR_IDLE;
  endtask

  task automatic rand_s(output b_cache_pkg::word_t s11, output b_cache_pkg::word_t s21,
                        output b_cache_pkg::word_t s22);
    logic [31:0] r;
    s11 = rand_bits(20);
    s22 = rand_bits(20);
    r   = rand_bits(18);
    s21 = {{14{r[17]}}, r[17:0]};
  endtask

  task automatic run_inverse(input b_cache_pkg::word_t s11, input b_cache_pkg::word_t s21,
                             input b_cache_pkg::word_t s22);
    hold_request(s11, s21, s22);
    accept_request();
    wait_done();
    read_inverse(s11, s21, s22);
  endtask

  // second request held while the first is still running
  task automatic overlap_inverse();
    b_cache_pkg::word_t a [3];
    b_cache_pkg::word_t b [3];
    rand_s(a[0], a[1], a[2]);
    rand_s(b[0], b[1], b[2]);
    hold_request(a[0], a[1], a[2]);
    accept_request();
    hold_request(b[0], b[1], b[2]);
    check_bit(s_ready, 1'b0, "s_ready while busy");
    wait_done();
    check_bit(s_ready, 1'b0, "s_ready in the done cycle");
    accept_request();
    read_inverse(a[0], a[1], a[2]);
    wait_done();
    read_inverse(b[0], b[1], b[2]);
  endtask

  initial begin
    b_cache_pkg::lane_vec_t zero;
    b_cache_pkg::word_t     s11;
    b_cache_pkg::word_t     s21;
    b_cache_pkg::word_t     s22;
    zero         = '{default: '0};
    lfsr         = 32'h5cdf5909;
    sys_rst      = 1'b1;
    cache_in_sel = b_cache_pkg::WR_NL_UPD;   // live mode and request held through reset
    seq_cnt      = b_cache_pkg::seq_cnt_t'(1);
    s_valid      = 1'b1;
    randomize_data();
    repeat (3) @(posedge clk);
    @(negedge clk);
    sys_rst      = 1'b0;
    s_valid      = 1'b0;
    cache_in_sel = b_cache_pkg::WR_IDLE;
    check_lanes(cache_din, zero, "cache_din after reset");
    check_bit(done_inv, 1'b0, "done_inv after reset");
    check_bit(s_ready, 1'b1, "s_ready after reset");

    test_nl_upd();
    test_chi();
    for (int k = 0; k < 5; k++) begin
      rand_s(s11, s21, s22);
      run_inverse(s11, s21, s22);
    end
    // s11q = s22q = s21 = one gives a zero determinant
    run_inverse(`B_CACHE_ONE - `B_CACHE_Q11, `B_CACHE_ONE, `B_CACHE_ONE - `B_CACHE_Q22);
    overlap_inverse();
    test_unused();

    $display("Everything OK");
    $finish;
  end

endmodule
